// File: verilog/audio_pkg.sv
package audio_pkg;

    // Sample memory and datapath sizes.
    localparam int SAMPLE_DEPTH = 256;
    localparam int ADDR_W       = $clog2(SAMPLE_DEPTH);
    localparam int POS_W        = 24;
    localparam int DELTA_W      = 12;
    localparam int SAMPLE_W     = 16;
    localparam int VOL_W        = 8;
    localparam int FRAME_BITS   = 32;
    localparam int FRAME_CNT_W  = $clog2(FRAME_BITS);

    localparam int APB_AW = 10;
    localparam int APB_DW = 32;

    // Register map, in word addresses.
    localparam logic [APB_AW-1:0] REG_START_ADDR   = 10'd0;
    localparam logic [APB_AW-1:0] REG_SAMPLE_COUNT = 10'd1;
    localparam logic [APB_AW-1:0] REG_LOOP_START   = 10'd2;
    localparam logic [APB_AW-1:0] REG_LOOP_END     = 10'd3;
    localparam logic [APB_AW-1:0] REG_POSITION     = 10'd4;
    localparam logic [APB_AW-1:0] REG_LAST_SAMPLE  = 10'd5;
    localparam logic [APB_AW-1:0] REG_VOLUME       = 10'd6;
    localparam logic [APB_AW-1:0] REG_CONTROL      = 10'd7;
    localparam logic [APB_AW-1:0] REG_STATUS       = 10'd8;
    localparam int                MEM_BASE         = 256;

    // Bit positions in REG_CONTROL. REG_STATUS carries playing at STATUS_PLAY.
    localparam int CTRL_PLAY    = 0;
    localparam int CTRL_LOOPING = 1;
    localparam int CTRL_MONO    = 2;
    localparam int CTRL_LEFT    = 3;
    localparam int STATUS_PLAY  = 24;

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [APB_AW-1:0] paddr;
        logic [APB_DW-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [APB_DW-1:0] prdata;
        logic              pready;
        logic              pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic [ADDR_W-1:0] start_addr;
        logic [POS_W-1:0]  sample_count;
        logic [POS_W-1:0]  loop_start;
        logic [POS_W-1:0]  loop_end;
        logic [VOL_W-1:0]  volume;
        logic              looping;
        logic              mono;
        logic              left;
    } ch_cfg_t;

    typedef struct packed {
        logic                pos_load;
        logic [POS_W-1:0]    pos_value;
        logic                last_load;
        logic [SAMPLE_W-1:0] last_value;
        logic                play_load;
        logic                play_value;
    } ch_load_t;

    typedef struct packed {
        logic [POS_W-1:0] position;
        logic             playing;
    } ch_state_t;

endpackage

// File: verilog/channel_regs.sv
`timescale 1ns/1ps
module channel_regs (
    input  logic                            clk_1024khz,
    input  logic                            i_rst_n,
    input  audio_pkg::apb_req_t             i_apb,
    output audio_pkg::apb_rsp_t             o_apb,
    input  audio_pkg::ch_state_t            i_state,
    output audio_pkg::ch_cfg_t              o_cfg,
    output audio_pkg::ch_load_t             o_load,
    output logic                            o_mem_we,
    output logic [audio_pkg::ADDR_W-1:0]    o_mem_addr,
    output logic [audio_pkg::DELTA_W-1:0]   o_mem_wdata
);
    import audio_pkg::*;

    logic              access;
    logic              wr;
    logic              rd;
    logic              in_regs;
    logic              in_mem;
    logic [APB_DW-1:0] rdata;

    assign access  = i_apb.psel & i_apb.penable;
    assign wr      = access & i_apb.pwrite;
    assign rd      = access & ~i_apb.pwrite;
    assign in_regs = (i_apb.paddr <= REG_STATUS);
    assign in_mem  = (i_apb.paddr >= MEM_BASE) && (i_apb.paddr < MEM_BASE + SAMPLE_DEPTH);

    // Zero wait states, and the delta window is write only.
    assign o_apb.pready  = 1'b1;
    assign o_apb.prdata  = rdata;
    assign o_apb.pslverr = access & ((~in_regs & ~in_mem) |
                                     (wr & (i_apb.paddr == REG_STATUS)) |
                                     (rd & in_mem));

    always_ff @(posedge clk_1024khz or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_cfg    <= '0;
            o_load   <= '0;
            o_mem_we <= 1'b0;
        end else begin
            o_load.pos_load  <= 1'b0;
            o_load.last_load <= 1'b0;
            o_load.play_load <= 1'b0;
            o_mem_we         <= wr & in_mem;
            if (wr && in_regs) begin
                case (i_apb.paddr)
                    REG_START_ADDR:   o_cfg.start_addr   <= i_apb.pwdata[ADDR_W-1:0];
                    REG_SAMPLE_COUNT: o_cfg.sample_count <= i_apb.pwdata[POS_W-1:0];
                    REG_LOOP_START:   o_cfg.loop_start   <= i_apb.pwdata[POS_W-1:0];
                    REG_LOOP_END:     o_cfg.loop_end     <= i_apb.pwdata[POS_W-1:0];
                    REG_VOLUME:       o_cfg.volume       <= i_apb.pwdata[VOL_W-1:0];
                    REG_POSITION: begin
                        o_load.pos_load  <= 1'b1;
                        o_load.pos_value <= i_apb.pwdata[POS_W-1:0];
                    end
                    REG_LAST_SAMPLE: begin
                        o_load.last_load  <= 1'b1;
                        o_load.last_value <= i_apb.pwdata[SAMPLE_W-1:0];
                    end
                    REG_CONTROL: begin
                        o_load.play_load  <= 1'b1;
                        o_load.play_value <= i_apb.pwdata[CTRL_PLAY];
                        o_cfg.looping     <= i_apb.pwdata[CTRL_LOOPING];
                        o_cfg.mono        <= i_apb.pwdata[CTRL_MONO];
                        o_cfg.left        <= i_apb.pwdata[CTRL_LEFT];
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk_1024khz) begin
        o_mem_addr  <= i_apb.paddr[ADDR_W-1:0];
        o_mem_wdata <= i_apb.pwdata[DELTA_W-1:0];
    end

    // Position and last sample read back the value last written, not the live one.
    always_comb begin
        rdata = '0;
        case (i_apb.paddr)
            REG_START_ADDR:   rdata[ADDR_W-1:0]   = o_cfg.start_addr;
            REG_SAMPLE_COUNT: rdata[POS_W-1:0]    = o_cfg.sample_count;
            REG_LOOP_START:   rdata[POS_W-1:0]    = o_cfg.loop_start;
            REG_LOOP_END:     rdata[POS_W-1:0]    = o_cfg.loop_end;
            REG_POSITION:     rdata[POS_W-1:0]    = o_load.pos_value;
            REG_LAST_SAMPLE:  rdata[SAMPLE_W-1:0] = o_load.last_value;
            REG_VOLUME:       rdata[VOL_W-1:0]    = o_cfg.volume;
            REG_CONTROL: begin
                rdata[CTRL_PLAY]    = i_state.playing;
                rdata[CTRL_LOOPING] = o_cfg.looping;
                rdata[CTRL_MONO]    = o_cfg.mono;
                rdata[CTRL_LEFT]    = o_cfg.left;
            end
            REG_STATUS: begin
                rdata[POS_W-1:0]  = i_state.position;
                rdata[STATUS_PLAY] = i_state.playing;
            end
            default: ;
        endcase
    end

endmodule

// File: verilog/delta_mem.sv
`timescale 1ns/1ps
module delta_mem (
    input  logic                          clk_1024khz,
    input  logic                          i_we,
    input  logic [audio_pkg::ADDR_W-1:0]  i_waddr,
    input  logic [audio_pkg::DELTA_W-1:0] i_wdata,
    input  logic [audio_pkg::ADDR_W-1:0]  i_raddr,
    output logic [audio_pkg::DELTA_W-1:0] o_rdata
);
    import audio_pkg::*;

    // Encoded waveform as downloaded by the host.
    logic [DELTA_W-1:0] mem [SAMPLE_DEPTH];

    always_ff @(posedge clk_1024khz) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // Registered read, data follows the address by one cycle.
    always_ff @(posedge clk_1024khz) begin
        o_rdata <= mem[i_raddr];
    end

endmodule

// File: verilog/channel_engine.sv
`timescale 1ns/1ps
module channel_engine (
    input  logic                           clk_1024khz,
    input  logic                           i_rst_n,
    input  audio_pkg::ch_cfg_t             i_cfg,
    input  audio_pkg::ch_load_t            i_load,
    input  logic                           i_frame,
    output logic [audio_pkg::ADDR_W-1:0]   o_mem_raddr,
    input  logic [audio_pkg::DELTA_W-1:0]  i_mem_rdata,
    output logic [audio_pkg::SAMPLE_W-1:0] o_left,
    output logic [audio_pkg::SAMPLE_W-1:0] o_right,
    output audio_pkg::ch_state_t           o_state
);
    import audio_pkg::*;

    // Step bits: 0 address out, 1 decode, 2 output.
    logic [2:0]                   step;
    logic                         active;
    logic                         playing;
    logic [POS_W-1:0]             position;
    logic [SAMPLE_W-1:0]          last_sample;
    logic [SAMPLE_W-1:0]          delta_ext;
    logic                         at_loop_end;
    logic                         at_count;
    logic signed [SAMPLE_W+VOL_W:0] product;
    logic [SAMPLE_W-1:0]          scaled;

    assign delta_ext   = {{(SAMPLE_W-DELTA_W){i_mem_rdata[DELTA_W-1]}}, i_mem_rdata};
    assign at_loop_end = i_cfg.looping && (position == i_cfg.loop_end);
    assign at_count    = !i_cfg.looping && (position + 1'b1 == i_cfg.sample_count);

    // Volume is unsigned, so it gets a zero sign bit before the signed multiply.
    assign product = $signed(last_sample) * $signed({1'b0, i_cfg.volume});
    assign scaled  = product[SAMPLE_W+VOL_W-1:VOL_W];

    assign o_state.position = position;
    assign o_state.playing  = playing;

    always_ff @(posedge clk_1024khz) begin
        if (i_frame) begin
            o_mem_raddr <= i_cfg.start_addr + position[ADDR_W-1:0];
        end
    end

    always_ff @(posedge clk_1024khz or negedge i_rst_n) begin
        if (!i_rst_n) begin
            step        <= '0;
            active      <= 1'b0;
            playing     <= 1'b0;
            position    <= '0;
            last_sample <= '0;
            o_left      <= '0;
            o_right     <= '0;
        end else begin
            step <= {step[1:0], i_frame};
            // The sequence always runs, so a stopped channel still clears its outputs.
            if (i_frame) begin
                active <= playing;
            end

            if (i_load.play_load) begin
                playing <= i_load.play_value;
            end else if (step[1] && active && at_count) begin
                playing <= 1'b0;
            end

            if (i_load.pos_load) begin
                position <= i_load.pos_value;
            end else if (step[1] && active) begin
                if (at_loop_end) begin
                    position <= i_cfg.loop_start;
                end else if (!at_count) begin
                    position <= position + 1'b1;
                end
            end

            if (i_load.last_load) begin
                last_sample <= i_load.last_value;
            end else if (step[1] && active) begin
                last_sample <= last_sample + delta_ext;
            end

            if (step[2]) begin
                if (!active) begin
                    o_left  <= '0;
                    o_right <= '0;
                end else if (i_cfg.mono) begin
                    o_left  <= scaled;
                    o_right <= scaled;
                end else if (i_cfg.left) begin
                    o_left  <= scaled;
                    o_right <= '0;
                end else begin
                    o_left  <= '0;
                    o_right <= scaled;
                end
            end
        end
    end

endmodule

// File: verilog/i2s_tx.sv
`timescale 1ns/1ps
module i2s_tx (
    input  logic                           clk_1024khz,
    input  logic                           i_rst_n,
    input  logic [audio_pkg::SAMPLE_W-1:0] i_left,
    input  logic [audio_pkg::SAMPLE_W-1:0] i_right,
    output logic                           o_frame,
    output logic                           o_lrclk,
    output logic                           o_din
);
    import audio_pkg::*;

    logic [FRAME_CNT_W-1:0] bit_cnt;
    logic [FRAME_CNT_W-1:0] bit_cnt_next;
    logic                   wrap;
    logic [2*SAMPLE_W-1:0]  shreg;

    assign wrap         = (bit_cnt == FRAME_CNT_W'(FRAME_BITS - 1));
    assign bit_cnt_next = wrap ? '0 : bit_cnt + 1'b1;
    assign o_frame      = (bit_cnt == '0);

    // Word clock and data are registered against the next count value,
    // so they line up with the counter in the same cycle.
    always_ff @(posedge clk_1024khz or negedge i_rst_n) begin
        if (!i_rst_n) begin
            bit_cnt <= '0;
            o_lrclk <= 1'b0;
            o_din   <= 1'b0;
        end else begin
            bit_cnt <= bit_cnt_next;
            o_lrclk <= (bit_cnt_next >= FRAME_CNT_W'(FRAME_BITS / 2));
            if (wrap) begin
                o_din <= i_left[SAMPLE_W-1];
            end else begin
                o_din <= shreg[2*SAMPLE_W-1];
            end
        end
    end

    // Both words are taken at frame start; left bit 15 goes out directly.
    always_ff @(posedge clk_1024khz) begin
        if (wrap) begin
            shreg <= {i_left[SAMPLE_W-2:0], i_right, 1'b0};
        end else begin
            shreg <= {shreg[2*SAMPLE_W-2:0], 1'b0};
        end
    end

endmodule

// File: verilog/audio_channel_top.sv
`timescale 1ns/1ps
module audio_channel_top (
    input  logic                clk_1024khz,
    input  logic                i_rst_n,
    input  audio_pkg::apb_req_t i_apb,
    output audio_pkg::apb_rsp_t o_apb,
    output logic                o_audio_bclk,
    output logic                o_audio_lrclk,
    output logic                o_audio_din,
    output logic                o_playing
);
    import audio_pkg::*;

    ch_cfg_t             cfg;
    ch_load_t            load;
    ch_state_t           state;
    logic                mem_we;
    logic [ADDR_W-1:0]   mem_waddr;
    logic [DELTA_W-1:0]  mem_wdata;
    logic [ADDR_W-1:0]   mem_raddr;
    logic [DELTA_W-1:0]  mem_rdata;
    logic                frame;
    logic [SAMPLE_W-1:0] left;
    logic [SAMPLE_W-1:0] right;

    // The bit clock is the system clock itself.
    assign o_audio_bclk = clk_1024khz;
    assign o_playing    = state.playing;

    channel_regs u_regs (
        .clk_1024khz (clk_1024khz),
        .i_rst_n     (i_rst_n),
        .i_apb       (i_apb),
        .o_apb       (o_apb),
        .i_state     (state),
        .o_cfg       (cfg),
        .o_load      (load),
        .o_mem_we    (mem_we),
        .o_mem_addr  (mem_waddr),
        .o_mem_wdata (mem_wdata)
    );

    delta_mem u_mem (
        .clk_1024khz (clk_1024khz),
        .i_we        (mem_we),
        .i_waddr     (mem_waddr),
        .i_wdata     (mem_wdata),
        .i_raddr     (mem_raddr),
        .o_rdata     (mem_rdata)
    );

    channel_engine u_engine (
        .clk_1024khz (clk_1024khz),
        .i_rst_n     (i_rst_n),
        .i_cfg       (cfg),
        .i_load      (load),
        .i_frame     (frame),
        .o_mem_raddr (mem_raddr),
        .i_mem_rdata (mem_rdata),
        .o_left      (left),
        .o_right     (right),
        .o_state     (state)
    );

    i2s_tx u_i2s (
        .clk_1024khz (clk_1024khz),
        .i_rst_n     (i_rst_n),
        .i_left      (left),
        .i_right     (right),
        .o_frame     (frame),
        .o_lrclk     (o_audio_lrclk),
        .o_din       (o_audio_din)
    );

endmodule

// File: sim/audio_monitor.sv
`timescale 1ns/1ps
module audio_monitor (
    input  logic        i_bclk,
    input  logic        i_lrclk,
    input  logic        i_din,
    input  logic        i_playing,
    output logic        o_done,
    output int          o_error_count
);
    logic [15:0] exp_left  [64];
    logic [15:0] exp_right [64];
    string       test_name = "";
    int          n_frames = 0;
    int          arm_seq = 0;
    int          arm_seen = 0;
    int          frame_idx = 0;
    int          frame_errors = 0;
    int          check_errors = 0;
    logic        prev_lr = 1'b0;
    logic [4:0]  bit_idx = 5'd0;
    logic [31:0] word = '0;
    logic        armed = 1'b0;
    logic        pending = 1'b0;
    logic        capturing = 1'b0;

    assign o_error_count = frame_errors + check_errors;

    task automatic load_frame(input int idx, input logic [15:0] left, input logic [15:0] right);
        exp_left[idx]  = left;
        exp_right[idx] = right;
    endtask

    task automatic arm(input string name, input int frames);
        test_name = name;
        n_frames  = frames;
        arm_seq   = arm_seq + 1;
    endtask

    task automatic check_word(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s: expected %h actual %h", what, expected, actual);
            check_errors = check_errors + 1;
        end
    endtask

    initial o_done = 1'b0;

    // Data is taken on the falling bit clock. A falling word clock marks bit 0 of a frame,
    // which starts with the left word.
    always @(negedge i_bclk) begin
        if (arm_seq != arm_seen) begin
            arm_seen  = arm_seq;
            armed     = 1'b1;
            pending   = 1'b0;
            capturing = 1'b0;
            frame_idx = 0;
            o_done    = 1'b0;
        end
        if (!i_lrclk && prev_lr) begin
            bit_idx = 5'd0;
        end else begin
            bit_idx = bit_idx + 5'd1;
        end
        word = {word[30:0], i_din};
        if (bit_idx == 5'd0) begin
            if (pending) begin
                pending   = 1'b0;
                capturing = 1'b1;
            end else if (armed && i_playing) begin
                // The fetch of this frame shows up on the pins one frame later.
                armed   = 1'b0;
                pending = 1'b1;
            end
        end
        if (capturing && bit_idx == 5'd31) begin
            if (word !== {exp_left[frame_idx], exp_right[frame_idx]}) begin
                $display("ERROR %s frame %0d: expected %h actual %h", test_name, frame_idx,
                         {exp_left[frame_idx], exp_right[frame_idx]}, word);
                frame_errors = frame_errors + 1;
            end
            frame_idx = frame_idx + 1;
            if (frame_idx == n_frames) begin
                capturing = 1'b0;
                o_done    = 1'b1;
            end
        end
        prev_lr = i_lrclk;
    end

endmodule

// File: sim/audio_channel_chk.sv
`timescale 1ns/1ps
module audio_channel_chk (
    input logic                clk_1024khz,
    input logic                i_rst_n,
    input audio_pkg::apb_req_t i_apb,
    input audio_pkg::apb_rsp_t o_apb,
    input logic                o_audio_lrclk,
    input logic                o_playing
);
    import audio_pkg::*;

    logic       prev_lr;
    logic       seen;
    logic [4:0] gap;
    logic       ctrl_wr;
    logic [1:0] ctrl_wr_d;
    logic [1:0] play_bit_d;

    assign ctrl_wr = i_apb.psel & i_apb.penable & i_apb.pwrite &
                     (i_apb.paddr == REG_CONTROL);

    // Cycles since the last word clock edge.
    always_ff @(posedge clk_1024khz or negedge i_rst_n) begin
        if (!i_rst_n) begin
            prev_lr <= 1'b0;
            seen    <= 1'b0;
            gap     <= '0;
        end else begin
            prev_lr <= o_audio_lrclk;
            if (o_audio_lrclk != prev_lr) begin
                seen <= 1'b1;
                gap  <= '0;
            end else begin
                gap <= gap + 5'd1;
            end
        end
    end

    // A control write reaches the playing flag two cycles after its access phase.
    always_ff @(posedge clk_1024khz or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ctrl_wr_d  <= '0;
            play_bit_d <= '0;
        end else begin
            ctrl_wr_d  <= {ctrl_wr_d[0], ctrl_wr};
            play_bit_d <= {play_bit_d[0], i_apb.pwdata[CTRL_PLAY]};
        end
    end

    assert property (@(posedge clk_1024khz) disable iff (!i_rst_n) o_apb.pready)
        else $error("pready went low");

    assert property (@(posedge clk_1024khz) disable iff (!i_rst_n)
        seen && (o_audio_lrclk != prev_lr) |-> gap == 5'd15)
        else $error("word clock edge not 16 cycles after the previous one");

    assert property (@(posedge clk_1024khz) disable iff (!i_rst_n)
        ctrl_wr_d[1] |-> o_playing == play_bit_d[1])
        else $error("o_playing does not follow the play bit of a control write");

endmodule

bind audio_channel_top audio_channel_chk u_chk (.*);

// File: sim/tb_audio_channel.sv
`timescale 1ns/1ps
module tb_audio_channel;
    import audio_pkg::*;

    typedef struct packed {
        logic [7:0]  volume;
        logic        looping;
        logic        mono;
        logic        left;
        logic [23:0] loop_start;
        logic [23:0] loop_end;
        logic [23:0] count;
        logic [23:0] pos;
        logic [15:0] init;
        logic [7:0]  frames;
    } row_t;

    localparam int         N_ROWS         = 4;
    localparam int         SETUP_CYCLES   = 1200;
    localparam logic [7:0] START_ADDR_VAL = 8'd200;

    logic        clk_1024khz;
    logic        rst_n;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic        bclk;
    logic        lrclk;
    logic        din;
    logic        playing;
    logic        mon_done;
    int          mon_errors;
    logic [11:0] mem_model [SAMPLE_DEPTH];
    row_t        rows [N_ROWS];
    string       names [N_ROWS];
    int          cycles = 0;
    int          limit = 0;
    int          failed = 0;

    audio_channel_top i_dut (
        .clk_1024khz   (clk_1024khz),
        .i_rst_n       (rst_n),
        .i_apb         (apb_req),
        .o_apb         (apb_rsp),
        .o_audio_bclk  (bclk),
        .o_audio_lrclk (lrclk),
        .o_audio_din   (din),
        .o_playing     (playing)
    );

    audio_monitor u_mon (
        .i_bclk        (bclk),
        .i_lrclk       (lrclk),
        .i_din         (din),
        .i_playing     (playing),
        .o_done        (mon_done),
        .o_error_count (mon_errors)
    );

    initial begin
        clk_1024khz = 1'b0;
        forever #5 clk_1024khz = ~clk_1024khz;
    end

    always @(posedge clk_1024khz) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("Timeout after %0d cycles, the audio frames never completed", cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic apb_access(input logic wr, input logic [9:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        @(negedge clk_1024khz);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge clk_1024khz);
        apb_req.penable = 1'b1;
        #1;
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(negedge clk_1024khz);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic reg_write(input string what, input logic [9:0] addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b1, addr, data, rdata, err);
        u_mon.check_word({what, " pslverr"}, 32'd0, {31'd0, err});
    endtask

    task automatic reg_read_check(input string what, input logic [9:0] addr,
                                  input logic [31:0] expected);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b0, addr, 32'd0, rdata, err);
        u_mon.check_word(what, expected, rdata);
    endtask

    task automatic access_err_check(input string what, input logic wr, input logic [9:0] addr);
        logic [31:0] rdata;
        logic        err;
        apb_access(wr, addr, 32'h5A5, rdata, err);
        u_mon.check_word(what, 32'd1, {31'd0, err});
    endtask

    task automatic build_expected(input int r);
        logic [23:0] pos;
        logic [15:0] smp;
        logic [15:0] sc;
        logic [7:0]  a;
        logic        run;
        int          prod;
        int          f;
        pos = rows[r].pos;
        smp = rows[r].init;
        run = 1'b1;
        for (f = 0; f < int'(rows[r].frames); f++) begin
            if (!run) begin
                u_mon.load_frame(f, 16'd0, 16'd0);
            end else begin
                a    = START_ADDR_VAL + pos[7:0];
                smp  = smp + {{4{mem_model[a][11]}}, mem_model[a]};
                prod = $signed(smp) * int'(rows[r].volume);
                sc   = prod[23:8];
                if (rows[r].mono) begin
                    u_mon.load_frame(f, sc, sc);
                end else if (rows[r].left) begin
                    u_mon.load_frame(f, sc, 16'd0);
                end else begin
                    u_mon.load_frame(f, 16'd0, sc);
                end
                if (rows[r].looping && pos == rows[r].loop_end) begin
                    pos = rows[r].loop_start;
                end else if (!rows[r].looping && pos + 24'd1 == rows[r].count) begin
                    run = 1'b0;
                end else begin
                    pos = pos + 24'd1;
                end
            end
        end
    endtask

    task automatic run_row(input int r);
        logic [31:0] ctrl;
        int          err_before;
        err_before = mon_errors;
        ctrl = {28'd0, rows[r].left, rows[r].mono, rows[r].looping, 1'b0};
        // Stop first and let any fetch in flight settle before loading.
        reg_write(names[r], REG_CONTROL, ctrl);
        repeat (40) @(posedge clk_1024khz);
        reg_write(names[r], REG_START_ADDR, {24'd0, START_ADDR_VAL});
        reg_write(names[r], REG_SAMPLE_COUNT, {8'd0, rows[r].count});
        reg_write(names[r], REG_LOOP_START, {8'd0, rows[r].loop_start});
        reg_write(names[r], REG_LOOP_END, {8'd0, rows[r].loop_end});
        reg_write(names[r], REG_VOLUME, {24'd0, rows[r].volume});
        reg_write(names[r], REG_POSITION, {8'd0, rows[r].pos});
        reg_write(names[r], REG_LAST_SAMPLE, {16'd0, rows[r].init});
        build_expected(r);
        u_mon.arm(names[r], int'(rows[r].frames));
        reg_write(names[r], REG_CONTROL, ctrl | 32'd1);
        while (!mon_done) @(posedge clk_1024khz);
        if (!rows[r].looping) begin
            u_mon.check_word({names[r], " o_playing"}, 32'd0, {31'd0, playing});
        end
        report_test(names[r], mon_errors - err_before);
    endtask

    task automatic report_test(input string name, input int errs);
        if (errs == 0) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d errors", name, errs);
            failed = failed + 1;
        end
    endtask

    initial begin
        int i;
        int err_before;
        apb_req = '0;
        rst_n   = 1'b0;
        void'($urandom(26989));
        rows[0] = '{8'd255, 1'b1, 1'b1, 1'b0, 24'd10, 24'd17, 24'd0, 24'd10, 16'd0, 8'd20};
        rows[1] = '{8'd128, 1'b1, 1'b0, 1'b1, 24'd0, 24'd63, 24'd0, 24'd0, 16'd0, 8'd16};
        rows[2] = '{8'd200, 1'b1, 1'b0, 1'b0, 24'd90, 24'd120, 24'd0, 24'd100, 16'h1234, 8'd24};
        rows[3] = '{8'd255, 1'b0, 1'b1, 1'b0, 24'd0, 24'd0, 24'd40, 24'd30, 16'hFE0C, 8'd16};
        names[0] = "mono_loop";
        names[1] = "stereo_left";
        names[2] = "stereo_right";
        names[3] = "one_shot";
        for (i = 0; i < N_ROWS; i++) begin
            limit = limit + 32 * (int'(rows[i].frames) + 4);
        end
        limit = 2 * limit + SETUP_CYCLES;

        repeat (3) @(posedge clk_1024khz);
        @(negedge clk_1024khz);
        rst_n = 1'b1;

        for (i = 0; i < SAMPLE_DEPTH; i++) begin
            mem_model[i] = 12'($urandom % 4096);
            reg_write("mem_fill", 10'(MEM_BASE + i), {20'd0, mem_model[i]});
        end

        for (i = 0; i < N_ROWS; i++) begin
            run_row(i);
        end

        // The one-shot row stopped at its last position, which is the sample count minus one.
        err_before = mon_errors;
        reg_read_check("status", REG_STATUS, 32'd39);
        reg_read_check("control", REG_CONTROL, 32'd4);
        reg_write("registers", REG_VOLUME, 32'h5A);
        reg_read_check("volume", REG_VOLUME, 32'h5A);
        reg_write("registers", REG_LOOP_END, 32'h00ABCDEF);
        reg_read_check("loop_end", REG_LOOP_END, 32'h00ABCDEF);
        reg_write("registers", REG_SAMPLE_COUNT, 32'h00123456);
        reg_read_check("sample_count", REG_SAMPLE_COUNT, 32'h00123456);
        reg_write("registers", REG_START_ADDR, 32'h33);
        reg_read_check("start_addr", REG_START_ADDR, 32'h33);
        access_err_check("status write", 1'b1, REG_STATUS);
        access_err_check("unmapped write", 1'b1, 10'd100);
        access_err_check("memory read", 1'b0, 10'(MEM_BASE + 3));
        report_test("registers", mon_errors - err_before);

        $display("Tests: %0d run, %0d failed, %0d errors", N_ROWS + 1, failed, mon_errors);
        if (failed == 0 && mon_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: tb.f
verilog/audio_pkg.sv
verilog/channel_regs.sv
verilog/delta_mem.sv
verilog/channel_engine.sv
verilog/i2s_tx.sv
verilog/audio_channel_top.sv
sim/audio_monitor.sv
sim/audio_channel_chk.sv
sim/tb_audio_channel.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the audio channel testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -f tb.f --top-module tb_audio_channel \
    -Mdir obj_dir -o tb_audio_channel
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_audio_channel > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -qF "*** TEST PASSED ***" "$LOG"; then
    exit 0
else
    echo "Pass message not found in $LOG"
    exit 1
fi
